/* fetchFrontEnd.f */
verilog/isaPkg.sv
verilog/fetchPkg.sv
verilog/fetchCreditIf.sv
verilog/instructionMemory.sv
verilog/debugLoader.sv
verilog/fetchUnit.sv
verilog/instructionDecoder.sv
verilog/fetchFrontEnd.sv
tests/fetchFrontEndTb.sv

/* run.sh */
#!/bin/sh
# Build and run the fetch front end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--timescale 1ns/100ps \
	--top-module fetchFrontEndTb \
	-f fetchFrontEnd.f \
	-o fetchFrontEndSim

./obj_dir/fetchFrontEndSim 2>&1 | tee sim.log

if grep -q "Checks failed" sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q "All checks passed" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"

/* tests/fetchFrontEndTb.sv */
`timescale 1ns/100ps
`default_nettype none

module fetchFrontEndTb;

	localparam int memDepth    = 32;
	localparam int loadCredits = 2;
	localparam int decCredits  = 2;
	localparam int outCredits  = 4;

	localparam int resetCycles = 16;
	localparam int firstLoad   = 10; // Words before run 1
	localparam int midRunLoad  = 2;  // Sent while run 1 is busy
	localparam int secondLoad  = 6;
	localparam int thirdLoad   = 12; // Program ends at 30 of 32 words
	localparam int fetchedWords = firstLoad + (firstLoad + midRunLoad + secondLoad)
		+ (firstLoad + midRunLoad + secondLoad + thirdLoad);
	localparam int watchdogCycles = resetCycles + 200 * fetchedWords + 1000;

	logic            clk = 1'b0;
	logic            rstN;
	logic            loadValid;
	isaPkg::wordT    loadWord;
	logic            loadCredit;
	logic            runStart;
	logic            runDone;
	logic            outValid;
	isaPkg::decodedT outDecoded;
	logic            outCredit;

	logic [31:0]     rngState = 32'd43714;
	isaPkg::wordT    loadedWords[$]; // Every word the loader accepted, in order
	isaPkg::wordT    pending[$];     // Words still to send
	isaPkg::decodedT expected[$];    // Model results for the current run
	int heldCredits = loadCredits;
	int outstanding = 0;          // Outputs not yet credited back
	int doneCount;
	int outCount;
	int creditHoldPct = 0;
	int illegalSeen = 0;
	int negativeSeen = 0;
	logic startRequest = 1'b0;

	fetchFrontEnd #(
		.memDepth    (memDepth),
		.loadCredits (loadCredits),
		.decCredits  (decCredits),
		.outCredits  (outCredits)
	) i_fetchFrontEnd (
		.clk        (clk),
		.rstN       (rstN),
		.loadValid  (loadValid),
		.loadWord   (loadWord),
		.loadCredit (loadCredit),
		.runStart   (runStart),
		.runDone    (runDone),
		.outValid   (outValid),
		.outDecoded (outDecoded),
		.outCredit  (outCredit)
	);

	always #10 clk = ~clk; // 20 ns period

	////////////////////
	// Stimulus and model

	function automatic logic [31:0] nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	function automatic logic isKnownFunct(logic [5:0] fn);
		return (fn == isaPkg::fnAdd) || (fn == isaPkg::fnSub) || (fn == isaPkg::fnAnd)
			|| (fn == isaPkg::fnOr) || (fn == isaPkg::fnSlt);
	endfunction

	// Random word of one of eight kinds
	function automatic isaPkg::wordT makeWord();
		logic [31:0]   r;
		logic [31:0]   kind;
		isaPkg::instrU u;
		r    = nextRandom();
		kind = nextRandom() % 8;
		u    = r; // Random fields everywhere
		case (kind)
			0, 1:
			begin
				u.r.opcode = isaPkg::opSpecial;
				case (r[22:20])
					3'd0:    u.r.funct = isaPkg::fnAdd;
					3'd1:    u.r.funct = isaPkg::fnSub;
					3'd2:    u.r.funct = isaPkg::fnAnd;
					3'd3:    u.r.funct = isaPkg::fnOr;
					default: u.r.funct = isaPkg::fnSlt;
				endcase
			end
			2: u.i.opcode = isaPkg::opAddi;
			3: u.i.opcode = isaPkg::opLw;
			4: u.i.opcode = isaPkg::opSw;
			5: u.i.opcode = isaPkg::opBeq;
			6:
			begin
				// Unknown opcode
				if (u.i.opcode inside {isaPkg::opSpecial, isaPkg::opLw, isaPkg::opSw,
					isaPkg::opBeq, isaPkg::opAddi})
					u.i.opcode = 6'h3F;
			end
			default:
			begin
				u.r.opcode = isaPkg::opSpecial; // R group with unknown funct
				if (isKnownFunct(u.r.funct))
					u.r.funct = 6'h3F;
			end
		endcase
		return u;
	endfunction

	// Expected decoder output for one word
	function automatic isaPkg::decodedT expectDecode(isaPkg::wordT w);
		isaPkg::instrU   u;
		isaPkg::decodedT e;
		u = w;
		e = '0;
		if (u.r.opcode == isaPkg::opSpecial && isKnownFunct(u.r.funct))
		begin
			e.instrClass = isaPkg::clsAlu;
			e.rs         = u.r.rs;
			e.rt         = u.r.rt;
			e.rd         = u.r.rd;
			e.funct      = u.r.funct;
		end
		else if (u.i.opcode == isaPkg::opAddi || u.i.opcode == isaPkg::opLw
			|| u.i.opcode == isaPkg::opSw || u.i.opcode == isaPkg::opBeq)
		begin
			if (u.i.opcode == isaPkg::opAddi)
				e.instrClass = isaPkg::clsAluImm;
			else if (u.i.opcode == isaPkg::opLw)
				e.instrClass = isaPkg::clsLoad;
			else if (u.i.opcode == isaPkg::opSw)
				e.instrClass = isaPkg::clsStore;
			else
				e.instrClass = isaPkg::clsBranch;
			e.rs = u.i.rs;
			e.rt = u.i.rt;
			if (u.i.imm16[15])
				e.imm = {16'hFFFF, u.i.imm16}; // Negative immediate
			else
				e.imm = {16'h0000, u.i.imm16};
		end
		else
			e.instrClass = isaPkg::clsIllegal; // Everything else zero
		return e;
	endfunction

	////////////////////
	// Checks

	task automatic stopWithFailure(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic checkDecoded(input isaPkg::decodedT got, input isaPkg::decodedT exp,
		input string what);
		if (got !== exp)
			stopWithFailure($sformatf("Error at %0t ns: %s got %h expected %h",
				$time, what, got, exp));
	endtask

	task automatic checkCount(input fetchPkg::pcT got, input fetchPkg::pcT exp,
		input string what);
		if (got !== exp)
			stopWithFailure($sformatf("Error at %0t ns: %s is %0d expected %0d",
				$time, what, got, exp));
	endtask

	////////////////////
	// One clock cycle

	// Sample 2 ns past the edge and then drive
	task automatic stepCycle();
		isaPkg::decodedT exp;
		@(posedge clk);
		#2;
		if (loadCredit)
			heldCredits++;
		if (heldCredits > loadCredits)
			stopWithFailure("Load credits returned beyond the loader queue depth");
		if (runDone)
			doneCount++;
		if (outValid)
		begin
			if (expected.size() == 0)
				stopWithFailure("Decoded output appeared with no item expected");
			else
			begin
				exp = expected.pop_front();
				checkDecoded(outDecoded, exp, $sformatf("output %0d", outCount));
				if (exp.instrClass == isaPkg::clsIllegal)
					illegalSeen++;
				if (exp.imm[31])
					negativeSeen++;
				outCount++;
				outstanding++;
				if (outstanding > outCredits)
					stopWithFailure("outValid asserted without an output credit");
			end
		end

		// Consumer returns credits at random
		outCredit = 1'b0;
		if (outstanding > 0 && (nextRandom() % 100) >= creditHoldPct)
		begin
			outCredit = 1'b1;
			outstanding--;
		end

		// Load sender with random gaps
		loadValid = 1'b0;
		if (pending.size() > 0 && heldCredits > 0 && (nextRandom() % 3) != 0)
		begin
			loadWord  = pending.pop_front();
			loadValid = 1'b1;
			heldCredits--;
			loadedWords.push_back(loadWord);
		end

		runStart     = startRequest;
		startRequest = 1'b0;
	endtask

	task automatic queueWords(input int n);
		repeat (n)
			pending.push_back(makeWord());
	endtask

	// Until every word is written and every credit is back
	task automatic finishLoad();
		while (pending.size() > 0 || heldCredits != loadCredits)
			stepCycle();
	endtask

	task automatic runProgram(input int duringRun, input int holdPct);
		foreach (loadedWords[k])
			expected.push_back(expectDecode(loadedWords[k]));
		doneCount     = 0;
		outCount      = 0;
		creditHoldPct = holdPct;
		startRequest  = 1'b1;
		stepCycle();
		repeat (3)
			stepCycle();
		queueWords(duringRun); // Held by the loader until the run ends
		startRequest = 1'b1;   // Extra pulse mid run is ignored
		while (doneCount == 0 || expected.size() > 0)
			stepCycle();
		creditHoldPct = 0;
		repeat (20)
			stepCycle(); // No late output or second runDone
		checkCount(doneCount, 1, "runDone pulses");
	endtask

	////////////////////
	// Main sequence

	initial
	begin
		rstN      = 1'b0;
		loadValid = 1'b0;
		loadWord  = '0;
		runStart  = 1'b0;
		outCredit = 1'b0;
		repeat (resetCycles)
			@(posedge clk);
		#2;
		rstN = 1'b1;
		checkCount(fetchPkg::pcT'({loadCredit, outValid, runDone}), 0, "outputs after reset");

		queueWords(firstLoad);
		finishLoad();
		runProgram(midRunLoad, 30); // Light back-pressure

		queueWords(secondLoad); // Appends after the held words
		finishLoad();
		runProgram(0, 0);

		queueWords(thirdLoad);
		finishLoad();
		runProgram(0, 70); // Heavy back-pressure

		if (illegalSeen == 0 || negativeSeen == 0)
			stopWithFailure("Stimulus never produced an illegal word or a negative immediate");
		else
		begin
			$display("All checks passed");
			$finish;
		end
	end

	// Hang guard
	initial
	begin
		repeat (watchdogCycles)
			@(posedge clk);
		stopWithFailure("Timeout: the DUT stopped making progress and the run did not finish");
	end

endmodule

`default_nettype wire

/* verilog/fetchFrontEnd.sv */
`timescale 1ns/100ps
`default_nettype none

module fetchFrontEnd #(
	parameter int memDepth    = 32,
	parameter int loadCredits = 2,
	parameter int decCredits  = 2,
	parameter int outCredits  = 4
) (
	input  logic            clk,
	input  logic            rstN,

	// Debug load stream
	input  logic            loadValid,
	input  isaPkg::wordT    loadWord,
	output logic            loadCredit,

	// Run control
	input  logic            runStart,
	output logic            runDone,

	// Decoded stream
	output logic            outValid,
	output isaPkg::decodedT outDecoded,
	input  logic            outCredit
);

	logic         fetchBusy;
	fetchPkg::pcT programLength;
	logic         readEn;
	fetchPkg::pcT readAddr;
	isaPkg::wordT readData;
	logic         writeEn;
	fetchPkg::pcT writeAddr;
	isaPkg::wordT writeData;

	fetchCreditIf fetchLink (); // Fetch to decode

	instructionMemory #(
		.memDepth (memDepth)
	) i_instructionMemory (
		.clk       (clk),
		.rstN      (rstN),
		.readEn    (readEn),
		.readAddr  (readAddr),
		.readData  (readData),
		.writeEn   (writeEn),
		.writeAddr (writeAddr),
		.writeData (writeData)
	);

	debugLoader #(
		.memDepth    (memDepth),
		.loadCredits (loadCredits)
	) i_debugLoader (
		.clk           (clk),
		.rstN          (rstN),
		.loadValid     (loadValid),
		.loadWord      (loadWord),
		.loadCredit    (loadCredit),
		.fetchBusy     (fetchBusy),
		.writeEn       (writeEn),
		.writeAddr     (writeAddr),
		.writeData     (writeData),
		.programLength (programLength)
	);

	fetchUnit #(
		.decCredits (decCredits)
	) i_fetchUnit (
		.clk           (clk),
		.rstN          (rstN),
		.runStart      (runStart),
		.runDone       (runDone),
		.programLength (programLength),
		.fetchBusy     (fetchBusy),
		.readEn        (readEn),
		.readAddr      (readAddr),
		.readData      (readData),
		.toDecode      (fetchLink.fetch)
	);

	instructionDecoder #(
		.decCredits (decCredits),
		.outCredits (outCredits)
	) i_instructionDecoder (
		.clk        (clk),
		.rstN       (rstN),
		.fromFetch  (fetchLink.decode),
		.outValid   (outValid),
		.outDecoded (outDecoded),
		.outCredit  (outCredit)
	);

endmodule

`default_nettype wire

/* verilog/instructionDecoder.sv */
`timescale 1ns/100ps
`default_nettype none

module instructionDecoder #(
	parameter int decCredits = 2,
	parameter int outCredits = 4
) (
	input  logic            clk,
	input  logic            rstN,
	fetchCreditIf.decode    fromFetch,
	output logic            outValid,
	output isaPkg::decodedT outDecoded,
	input  logic            outCredit   // Consumer freed one slot
);

	localparam int ptrW = (decCredits > 1) ? $clog2(decCredits) : 1;
	localparam logic [ptrW-1:0] lastSlot = ptrW'(decCredits - 1);
	localparam logic [fetchPkg::creditW-1:0] fullCount = decCredits[fetchPkg::creditW-1:0];
	localparam logic [fetchPkg::creditW-1:0] outStart = outCredits[fetchPkg::creditW-1:0];

	isaPkg::wordT                 queue [decCredits]; // Fetched words
	logic [ptrW-1:0]              wrPtr;
	logic [ptrW-1:0]              rdPtr;
	logic [fetchPkg::creditW-1:0] count;
	logic [fetchPkg::creditW-1:0] outCnt; // Credits toward the consumer
	logic                         push;
	logic                         pop;
	isaPkg::instrU                head;

	assign push = fromFetch.valid;
	assign pop  = (count != '0) && (outCnt != '0);
	assign head = queue[rdPtr];

	////////////////////
	// Decode rule

	function automatic isaPkg::decodedT decodeWord(isaPkg::instrU ins);
		isaPkg::decodedT d;
		d            = '0;
		d.instrClass = isaPkg::clsIllegal; // Default with all fields zero
		d.rs         = ins.i.rs;
		d.rt         = ins.i.rt;
		d.imm        = {{16{ins.i.imm16[15]}}, ins.i.imm16};
		case (ins.i.opcode)
			isaPkg::opAddi: d.instrClass = isaPkg::clsAluImm;
			isaPkg::opLw:   d.instrClass = isaPkg::clsLoad;
			isaPkg::opSw:   d.instrClass = isaPkg::clsStore;
			isaPkg::opBeq:  d.instrClass = isaPkg::clsBranch;
			isaPkg::opSpecial:
			begin
				d.imm = '0; // R view
				if (ins.r.funct inside {isaPkg::fnAdd, isaPkg::fnSub, isaPkg::fnAnd,
					isaPkg::fnOr, isaPkg::fnSlt})
				begin
					d.instrClass = isaPkg::clsAlu;
					d.rd         = ins.r.rd;
					d.funct      = ins.r.funct;
				end
			end
			default: d.instrClass = isaPkg::clsIllegal;
		endcase
		if (d.instrClass == isaPkg::clsIllegal)
			d = '{instrClass: isaPkg::clsIllegal, default: '0};
		return d;
	endfunction

	////////////////////
	// Queue and output

	always_ff @(posedge clk)
	begin
		if (push)
			queue[wrPtr] <= fromFetch.item.word;
		if (pop)
			outDecoded <= decodeWord(head);
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			wrPtr                  <= '0;
			rdPtr                  <= '0;
			count                  <= '0;
			outCnt                 <= outStart;
			outValid               <= 1'b0;
			fromFetch.creditReturn <= 1'b0;
		end
		else
		begin
			if (push)
				wrPtr <= (wrPtr == lastSlot) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == lastSlot) ? '0 : rdPtr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
			if (pop && !outCredit)
				outCnt <= outCnt - 1'b1;
			else if (outCredit && !pop)
				outCnt <= outCnt + 1'b1;
			outValid               <= pop; // Cycle after the pop
			fromFetch.creditReturn <= pop; // Entry freed
		end
	end

	// Fetch must hold a credit for each item
	queueOverflow: assert property (@(posedge clk) disable iff (!rstN)
		push |-> (count < fullCount))
		else $error("instructionDecoder queue overflow");

endmodule

`default_nettype wire

/* verilog/fetchUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module fetchUnit #(
	parameter int decCredits = 2
) (
	input  logic         clk,
	input  logic         rstN,
	input  logic         runStart,      // One cycle pulse
	output logic         runDone,       // One cycle pulse
	input  fetchPkg::pcT programLength,
	output logic         fetchBusy,

	// Memory read port
	output logic         readEn,
	output fetchPkg::pcT readAddr,
	input  isaPkg::wordT readData,

	fetchCreditIf.fetch  toDecode
);

	localparam logic [fetchPkg::creditW-1:0] fullCredits = decCredits[fetchPkg::creditW-1:0];

	logic                         running;
	fetchPkg::pcT                 pc;       // Next word to read
	fetchPkg::pcT                 issuedPc; // Address of the read in flight
	logic [fetchPkg::creditW-1:0] credits;  // Free decoder entries
	logic                         atEnd;

	assign atEnd     = (pc >= programLength);
	assign readEn    = running && !atEnd && (credits != '0);
	assign readAddr  = pc;
	assign fetchBusy = running; // Loader waits

	////////////////////
	// Run control

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			running <= 1'b0;
			pc      <= '0;
			runDone <= 1'b0;
		end
		else
		begin
			runDone <= running && atEnd; // Cycle after the last item
			if (!running && runStart)
			begin
				running <= 1'b1;
				pc      <= '0; // Every run starts at address zero
			end
			else if (running && atEnd)
				running <= 1'b0;
			else if (readEn)
				pc <= pc + 1'b1; // Sequential only
		end
	end

	////////////////////
	// Item out and credits

	// Memory data lands one cycle after the read
	always_ff @(posedge clk)
	begin
		if (readEn)
			issuedPc <= pc;
	end

	assign toDecode.item = '{pc: issuedPc, word: readData};

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			toDecode.valid <= 1'b0;
			credits        <= fullCredits; // Decoder queue depth
		end
		else
		begin
			toDecode.valid <= readEn;
			case ({readEn, toDecode.creditReturn})
				2'b10:   credits <= credits - 1'b1; // Spent at issue
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;        // Both or neither
			endcase
		end
	end

	// Returns from the decoder never exceed what was spent
	creditBound: assert property (@(posedge clk) disable iff (!rstN)
		credits <= fullCredits)
		else $error("fetchUnit credit counter out of range");

endmodule

`default_nettype wire

/* verilog/debugLoader.sv */
`timescale 1ns/100ps
`default_nettype none

module debugLoader #(
	parameter int memDepth    = 32,
	parameter int loadCredits = 2
) (
	input  logic         clk,
	input  logic         rstN,
	input  logic         loadValid,
	input  isaPkg::wordT loadWord,
	output logic         loadCredit,    // One pulse per freed entry
	input  logic         fetchBusy,     // Memory belongs to fetch
	output logic         writeEn,
	output fetchPkg::pcT writeAddr,
	output isaPkg::wordT writeData,
	output fetchPkg::pcT programLength  // Words loaded so far
);

	localparam int ptrW = (loadCredits > 1) ? $clog2(loadCredits) : 1;
	localparam logic [ptrW-1:0] lastSlot = ptrW'(loadCredits - 1);
	localparam logic [fetchPkg::creditW-1:0] fullCount = loadCredits[fetchPkg::creditW-1:0];
	localparam fetchPkg::pcT depthLimit = memDepth;

	isaPkg::wordT queue [loadCredits]; // Words waiting for the memory
	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	logic [fetchPkg::creditW-1:0] count;
	logic empty;
	logic drain;   // One word leaves this cycle
	logic bypass;  // Incoming word goes straight to memory
	logic push;
	logic pop;
	logic inRange; // Next address still fits

	assign empty   = (count == '0);
	assign drain   = !fetchBusy && (!empty || loadValid);
	assign bypass  = drain && empty;
	assign pop     = drain && !empty;
	assign push    = loadValid && !bypass;
	assign inRange = (programLength < depthLimit);

	assign writeEn   = drain && inRange; // Out of range words vanish
	assign writeAddr = programLength;    // Sequential addresses
	assign writeData = empty ? loadWord : queue[rdPtr];

	always_ff @(posedge clk)
	begin
		if (push)
			queue[wrPtr] <= loadWord;
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			wrPtr         <= '0;
			rdPtr         <= '0;
			count         <= '0;
			loadCredit    <= 1'b0;
			programLength <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= (wrPtr == lastSlot) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == lastSlot) ? '0 : rdPtr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
			loadCredit <= drain; // Credit one cycle after the write
			if (writeEn)
				programLength <= programLength + 1'b1;
		end
	end

	////////////////////
	// Checks

	// Sender must respect its credits
	queueOverflow: assert property (@(posedge clk) disable iff (!rstN)
		push |-> (count < fullCount))
		else $error("debugLoader queue overflow");

	// Program larger than the memory
	loadDropped: assert property (@(posedge clk) disable iff (!rstN)
		drain |-> inRange)
		else $error("debugLoader word beyond memDepth dropped");

endmodule

`default_nettype wire

/* verilog/instructionMemory.sv */
`timescale 1ns/100ps
`default_nettype none

module instructionMemory #(
	parameter int memDepth = 32
) (
	input  logic         clk,
	input  logic         rstN,

	// Fetch read path
	input  logic         readEn,
	input  fetchPkg::pcT readAddr,
	output isaPkg::wordT readData,

	// Debug write path
	input  logic         writeEn,
	input  fetchPkg::pcT writeAddr,
	input  isaPkg::wordT writeData
);

	localparam int addrW = (memDepth > 1) ? $clog2(memDepth) : 1;
	localparam fetchPkg::pcT depthLimit = memDepth;

	isaPkg::wordT memory [memDepth]; // Program store

	// Write on the rising edge
	always_ff @(posedge clk)
	begin
		if (writeEn)
			memory[writeAddr[addrW-1:0]] <= writeData;
	end

	// Registered read that holds until the next one
	always_ff @(posedge clk)
	begin
		if (readEn)
			readData <= memory[readAddr[addrW-1:0]];
	end

	////////////////////
	// Checks

	// Loader and fetch take turns on the memory
	readWriteExclusive: assert property (@(posedge clk) disable iff (!rstN)
		!(readEn && writeEn))
		else $error("instructionMemory read and write in the same cycle");

	// Both paths stay inside the array
	addrInRange: assert property (@(posedge clk) disable iff (!rstN)
		(readEn -> (readAddr < depthLimit)) && (writeEn -> (writeAddr < depthLimit)))
		else $error("instructionMemory address beyond memDepth");

endmodule

`default_nettype wire

/* verilog/fetchCreditIf.sv */
`timescale 1ns/100ps
`default_nettype none

// Fetch to decode link under credit flow control
interface fetchCreditIf;

	logic                valid;        // One item this cycle
	fetchPkg::fetchItemT item;         // PC plus word
	logic                creditReturn; // Decoder freed one entry

	// Sender side
	modport fetch
	(
		output valid,
		output item,
		input  creditReturn
	);

	// Receiver side
	modport decode
	(
		input  valid,
		input  item,
		output creditReturn
	);

endinterface

`default_nettype wire

/* verilog/fetchPkg.sv */
`default_nettype none

package fetchPkg;

	// Widths of the front end counters
	localparam int pcW     = 32; // Word address
	localparam int creditW = 4;  // Every credit and queue counter

	typedef logic [pcW-1:0] pcT;

	// One fetched word tagged with its address
	typedef struct packed
	{
		pcT           pc;
		isaPkg::wordT word;
	} fetchItemT;

endpackage

`default_nettype wire

/* verilog/isaPkg.sv */
`default_nettype none

package isaPkg;

	////////////////////
	// Instruction word and its two views

	typedef logic [31:0] wordT;

	typedef struct packed
	{
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFormatT; // Register format

	typedef struct packed
	{
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} iFormatT; // Immediate format

	typedef union packed
	{
		rFormatT r;
		iFormatT i;
	} instrU; // Same 32 bits seen both ways

	////////////////////
	// Opcodes and funct codes

	localparam logic [5:0] opSpecial = 6'h00; // R-format group
	localparam logic [5:0] opLw      = 6'h23;
	localparam logic [5:0] opSw      = 6'h2B;
	localparam logic [5:0] opBeq     = 6'h04;
	localparam logic [5:0] opAddi    = 6'h08;

	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr  = 6'h25;
	localparam logic [5:0] fnSlt = 6'h2A;

	typedef enum logic [2:0]
	{
		clsAlu,
		clsAluImm,
		clsLoad,
		clsStore,
		clsBranch,
		clsIllegal
	} instrClassT;

	// Decoder result, unused fields zero
	typedef struct packed
	{
		instrClassT  instrClass;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [5:0]  funct;
		logic [31:0] imm; // Sign extended imm16
	} decodedT;

endpackage

`default_nettype wire
